// ==== list.f ====
src/mem_pkg.sv
src/fetch_pkg.sv
src/icache.sv
src/next_pc_predict.sv
src/instr_fifo.sv
src/ifu.sv
test/ifu_props.sv
test/ifu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module ifu_tb -o ifu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ifu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides
if grep -qx "all tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== test/ifu_tb.sv ====
`default_nettype none

module ifu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk = 1'b0;
    logic rst = 1'b1;
    mem_pkg::addr_t recovery_pc = '0;
    logic recovery_valid = 1'b0;
    logic backend_stall = 1'b0;
    logic req_valid;
    mem_pkg::block_addr_t req_block_addr;
    logic req_ready = 1'b0;
    logic resp_valid = 1'b0;
    mem_pkg::block_data_t resp_block_data = '0;
    logic dispatch_valid;
    fetch_pkg::ifetch_entry_t dispatch_entry;
    logic dispatch_ready = 1'b0;

    // program image, 256 words, plus what the model knows of each word
    fetch_pkg::instr_t mem [256];
    fetch_pkg::opcode_t kind [256];
    int off [256];

    // random behavior switches
    bit rdy_rand = 1'b0;
    bit stall_rand = 1'b0;
    bit mem_bp = 1'b0;

    logic [6:0] pend_blk = '0;
    int resp_wait = 0;
    int req_total = 0;
    fetch_pkg::ifetch_entry_t got [$];
    int got_base = 0;
    int errors = 0;
    int ran_tests = 0;
    int failed_tests = 0;
    int num_tests = 6;

    ifu dut0 (
        .clk             (clk),
        .rst             (rst),
        .recovery_pc     (recovery_pc),
        .recovery_valid  (recovery_valid),
        .backend_stall   (backend_stall),
        .req_valid       (req_valid),
        .req_block_addr  (req_block_addr),
        .req_ready       (req_ready),
        .resp_valid      (resp_valid),
        .resp_block_data (resp_block_data),
        .dispatch_valid  (dispatch_valid),
        .dispatch_entry  (dispatch_entry),
        .dispatch_ready  (dispatch_ready)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // backend side, ready and stall
    always @(posedge clk) begin
        dispatch_ready <= rdy_rand ? ($urandom_range(0, 1) == 1) : 1'b1;
        backend_stall <= stall_rand ? ($urandom_range(0, 4) == 0) : 1'b0;
    end

    // memory controller, one block in flight
    always @(posedge clk) begin
        resp_valid <= 1'b0;
        if (rst) begin
            resp_wait <= 0;
            req_ready <= 1'b0;
        end else if (req_valid && req_ready) begin
            pend_blk <= req_block_addr[6:0];
            resp_wait <= $urandom_range(1, 6);
            req_ready <= 1'b0;
            req_total <= req_total + 1;
        end else if (resp_wait != 0) begin
            resp_wait <= resp_wait - 1;
            if (resp_wait == 1) begin
                resp_valid <= 1'b1;
                // even word in the low half
                resp_block_data <= {mem[{pend_blk, 1'b1}], mem[{pend_blk, 1'b0}]};
            end
        end else begin
            req_ready <= mem_bp ? ($urandom_range(0, 3) == 0) : 1'b1;
        end
    end

    // dispatched entries, in order
    always @(posedge clk) begin
        if (!rst && dispatch_valid && dispatch_ready) begin
            got.push_back(dispatch_entry);
        end
    end

    task automatic check_entry(string name, fetch_pkg::ifetch_entry_t act,
                               fetch_pkg::ifetch_entry_t exp);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_addr(string name, mem_pkg::addr_t act, mem_pkg::addr_t exp);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, act, exp);
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, act, exp);
        end
    endtask

    // isa encodings of jal and a beq with zero registers
    task automatic put_jal(logic [7:0] w, int o);
        logic [20:0] imm;
        imm = o[20:0];
        mem[w] = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, fetch_pkg::op_jal};
        kind[w] = fetch_pkg::op_jal;
        off[w] = o;
    endtask

    task automatic put_branch(logic [7:0] w, int o);
        logic [12:0] imm;
        imm = o[12:0];
        mem[w] = {imm[12], imm[10:5], 10'd0, 3'd0, imm[4:1], imm[11], fetch_pkg::op_branch};
        kind[w] = fetch_pkg::op_branch;
        off[w] = o;
    endtask

    task automatic load_program();
        int i;
        // addi-like filler, each word tagged with its own index
        for (i = 0; i < 256; i++) begin
            mem[i] = {i[24:0], 7'b0010011};
            kind[i] = fetch_pkg::op_other;
            off[i] = 0;
        end
        // loop at 0x100, closed by jal at 0x120
        put_jal(8'h48, -32);
        // 0x200 region, jal over two words, forward and backward branch
        put_jal(8'h81, 12);
        put_branch(8'h84, 8);
        put_branch(8'h86, -24);
    endtask

    // expected entry from the static prediction rule
    function automatic fetch_pkg::ifetch_entry_t model_entry(mem_pkg::addr_t pc);
        fetch_pkg::ifetch_entry_t e;
        logic [7:0] w;
        w = pc[9:2];
        e.instr = mem[w];
        e.pc = pc;
        e.is_cond_br = kind[w] == fetch_pkg::op_branch;
        e.br_dir_pred = e.is_cond_br && (off[w] < 0);
        if (kind[w] == fetch_pkg::op_jal || e.br_dir_pred) begin
            e.br_target_pred = pc + mem_pkg::addr_t'(off[w]);
        end else begin
            e.br_target_pred = pc + 32'd4;
        end
        return e;
    endfunction

    task automatic apply_reset();
        int i;
        @(posedge clk);
        rst <= 1'b1;
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            // first edge only starts the reset
            if (i > 0) begin
                check_bit("req_valid", req_valid, 1'b0);
                check_bit("dispatch_valid", dispatch_valid, 1'b0);
            end
        end
        rst <= 1'b0;
    endtask

    task automatic redirect(mem_pkg::addr_t target);
        @(posedge clk);
        recovery_valid <= 1'b1;
        recovery_pc <= target;
        @(posedge clk);
        recovery_valid <= 1'b0;
        @(negedge clk);
        got_base = got.size();
    endtask

    task automatic check_stream(mem_pkg::addr_t start, int n);
        mem_pkg::addr_t pc;
        fetch_pkg::ifetch_entry_t exp;
        int cyc;
        int i;
        cyc = 0;
        while (got.size() - got_base < n && cyc < 200 + 50 * n) begin
            @(negedge clk);
            cyc++;
        end
        if (got.size() - got_base < n) begin
            errors++;
            $display("timed out waiting for %0d dispatched entries, saw %0d",
                     n, got.size() - got_base);
        end
        pc = start;
        for (i = 0; i < n && got_base + i < got.size(); i++) begin
            exp = model_entry(pc);
            check_entry("dispatch_entry", got[got_base + i], exp);
            pc = exp.br_target_pred;
        end
    endtask

    task automatic finish_test(string name, int base);
        ran_tests++;
        if (errors == base) begin
            $display("test %s: pass", name);
        end else begin
            failed_tests++;
            $display("test %s: FAIL with %0d errors", name, errors - base);
        end
    endtask

    task automatic test_reset();
        int base;
        int cyc;
        base = errors;
        apply_reset();
        cyc = 0;
        @(negedge clk);
        while (!req_valid && cyc < 50) begin
            @(negedge clk);
            cyc++;
        end
        if (!req_valid) begin
            errors++;
            $display("no block request seen after reset");
        end else begin
            check_addr("req_block_addr", {req_block_addr, 3'b000}, fetch_pkg::reset_vector);
        end
        finish_test("reset", base);
    endtask

    task automatic test_straight();
        int base;
        int reqs;
        base = errors;
        // two passes of the nine word loop
        redirect(32'h100);
        check_stream(32'h100, 18);
        reqs = req_total;
        redirect(32'h100);
        check_stream(32'h100, 18);
        if (req_total != reqs) begin
            errors++;
            $display("cached loop sent %0d new block requests", req_total - reqs);
        end
        finish_test("straight", base);
    endtask

    task automatic test_predict();
        int base;
        base = errors;
        redirect(32'h200);
        check_stream(32'h200, 15);
        finish_test("predict", base);
    endtask

    task automatic test_backpressure();
        int base;
        base = errors;
        redirect(32'h200);
        rdy_rand = 1'b1;
        stall_rand = 1'b1;
        check_stream(32'h200, 40);
        rdy_rand = 1'b0;
        stall_rand = 1'b0;
        finish_test("backpressure", base);
    endtask

    task automatic test_redirect();
        int base;
        int cyc;
        base = errors;
        redirect(32'h200);
        check_stream(32'h200, 4);
        // cold code, then leave in the middle of its refill
        redirect(32'h300);
        cyc = 0;
        while (!req_valid && cyc < 50) begin
            @(negedge clk);
            cyc++;
        end
        if (!req_valid) begin
            errors++;
            $display("no refill started for the cold redirect target");
        end
        redirect(32'h100);
        check_stream(32'h100, 12);
        finish_test("redirect", base);
    endtask

    task automatic test_mem_backpressure();
        int base;
        base = errors;
        mem_bp = 1'b1;
        // reset empties the cache so every block is fetched again
        apply_reset();
        redirect(32'h100);
        check_stream(32'h100, 18);
        mem_bp = 1'b0;
        finish_test("mem_backpressure", base);
    endtask

    initial begin
        void'($urandom(32'h653e20c3));
        load_program();
        test_reset();
        test_straight();
        test_predict();
        test_backpressure();
        test_redirect();
        test_mem_backpressure();
        $display("%0d of %0d tests ok, %0d checks wrong",
                 ran_tests - failed_tests, ran_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // whole run budget
    initial begin
        repeat (num_tests * 2000) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ifu_props.sv ====
`default_nettype none

module ifu_props (
    input wire                           clk,
    input wire                           rst,
    input wire                           recovery_valid,
    input wire                           req_valid,
    input wire mem_pkg::block_addr_t     req_block_addr,
    input wire                           req_ready,
    input wire                           dispatch_valid,
    input wire fetch_pkg::ifetch_entry_t dispatch_entry,
    input wire                           dispatch_ready,
    input wire                           push,
    input wire                           full
);
    timeunit 1ns;
    timeprecision 1ps;

    // queue occupancy rebuilt from pushes, pops and flushes
    int occ;

    always_ff @(posedge clk) begin
        if (rst || recovery_valid) begin
            occ <= 0;
        end else begin
            occ <= occ + int'(push) - int'(dispatch_valid && dispatch_ready);
        end
    end

    // request held until memory takes it
    req_hold: assert property (@(posedge clk)
        req_valid && !req_ready && !rst |=> req_valid && $stable(req_block_addr))
        else $error("req_valid or req_block_addr dropped before req_ready");

    // a redirect flush may drop the head, anything else must hold
    dispatch_hold: assert property (@(posedge clk)
        dispatch_valid && !dispatch_ready && !rst && !recovery_valid
        |=> dispatch_valid && $stable(dispatch_entry))
        else $error("dispatch_valid or dispatch_entry dropped before dispatch_ready");

    // a queue holding depth entries flags full and takes no push
    no_push_full: assert property (@(posedge clk) disable iff (rst)
        occ == fetch_pkg::ififo_depth |-> full && !push)
        else $error("push into a full instruction FIFO or full flag low");

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !req_valid && !dispatch_valid)
        else $error("handshake valid high right after reset");

endmodule

bind ifu ifu_props props0 (
    .clk            (clk),
    .rst            (rst),
    .recovery_valid (recovery_valid),
    .req_valid      (req_valid),
    .req_block_addr (req_block_addr),
    .req_ready      (req_ready),
    .dispatch_valid (dispatch_valid),
    .dispatch_entry (dispatch_entry),
    .dispatch_ready (dispatch_ready),
    .push           (push),
    .full           (fifo_full)
);

`default_nettype wire

// ==== src/ifu.sv ====
`default_nettype none

module ifu (
    input  wire                       clk,
    input  wire                       rst,
    // redirect from the backend
    input  wire mem_pkg::addr_t       recovery_pc,
    input  wire                       recovery_valid,
    input  wire                       backend_stall,
    // icache to memory controller
    output logic                      req_valid,
    output mem_pkg::block_addr_t      req_block_addr,
    input  wire                       req_ready,
    // memory controller to icache
    input  wire                       resp_valid,
    input  wire mem_pkg::block_data_t resp_block_data,
    // to dispatch
    output logic                      dispatch_valid,
    output fetch_pkg::ifetch_entry_t  dispatch_entry,
    input  wire                       dispatch_ready
);

    mem_pkg::addr_t pc;
    mem_pkg::addr_t pc_next;
    mem_pkg::addr_t next_pc;
    mem_pkg::block_data_t block;
    fetch_pkg::instr_t instr;
    fetch_pkg::ifetch_entry_t push_entry;

    logic hit;
    logic fifo_full;
    logic fetch_stall;
    logic push;
    logic is_cond_br;
    logic br_dir_pred;

    // miss, queue full or backend hold
    assign fetch_stall = !hit || fifo_full || backend_stall;

    // nothing enters the queue while a redirect is taken
    assign push = !fetch_stall && !recovery_valid;

    // pc mux, redirect wins over everything
    always_comb begin
        if (recovery_valid) begin
            pc_next = recovery_pc;
        end else if (push) begin
            pc_next = next_pc;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= fetch_pkg::reset_vector;
        end else begin
            pc <= pc_next;
        end
    end

    // redirect doubles as cache flush, refill still completes
    icache u_icache (
        .clk             (clk),
        .rst             (rst),
        .pc              (pc),
        .flush           (recovery_valid),
        .hit             (hit),
        .block           (block),
        .req_valid       (req_valid),
        .req_block_addr  (req_block_addr),
        .req_ready       (req_ready),
        .resp_valid      (resp_valid),
        .resp_block_data (resp_block_data)
    );

    // pc bit 2 picks the word, upper word is the odd one
    assign instr = pc[2] ? block[2*fetch_pkg::instr_width-1:fetch_pkg::instr_width]
                         : block[fetch_pkg::instr_width-1:0];

    next_pc_predict u_next_pc_predict (
        .instr       (instr),
        .pc          (pc),
        .is_cond_br  (is_cond_br),
        .br_dir_pred (br_dir_pred),
        .next_pc     (next_pc)
    );

    // queue entry
    always_comb begin
        push_entry.instr = instr;
        push_entry.pc = pc;
        push_entry.is_cond_br = is_cond_br;
        push_entry.br_dir_pred = br_dir_pred;
        push_entry.br_target_pred = next_pc;
    end

    instr_fifo u_instr_fifo (
        .clk        (clk),
        .rst        (rst),
        .flush      (recovery_valid),
        .push       (push),
        .push_entry (push_entry),
        .full       (fifo_full),
        .pop_valid  (dispatch_valid),
        .pop_entry  (dispatch_entry),
        .pop_ready  (dispatch_ready)
    );

endmodule

`default_nettype wire

// ==== src/instr_fifo.sv ====
`default_nettype none

module instr_fifo (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       flush,
    // enqueue from fetch
    input  wire                       push,
    input  wire fetch_pkg::ifetch_entry_t push_entry,
    output logic                      full,
    // dequeue toward dispatch
    output logic                      pop_valid,
    output fetch_pkg::ifetch_entry_t  pop_entry,
    input  wire                       pop_ready
);

    fetch_pkg::ifetch_entry_t entries [fetch_pkg::ififo_depth];

    fetch_pkg::ififo_ptr_t   wr_ptr;
    fetch_pkg::ififo_ptr_t   rd_ptr;
    fetch_pkg::ififo_count_t count;

    logic do_push;
    logic do_pop;

    assign full = count == fetch_pkg::ififo_count_t'(fetch_pkg::ififo_depth);

    // straight from storage, so a new entry shows a cycle later
    assign pop_valid = count != '0;
    assign pop_entry = entries[rd_ptr];

    // push while full is dropped
    assign do_push = push && !full;
    assign do_pop = pop_valid && pop_ready;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // flush drops all queued entries
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // depth is a power of two, pointers wrap on their own
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

endmodule

`default_nettype wire

// ==== src/next_pc_predict.sv ====
`default_nettype none

module next_pc_predict (
    input  wire fetch_pkg::instr_t instr,
    input  wire mem_pkg::addr_t    pc,
    output logic                   is_cond_br,
    output logic                   br_dir_pred,
    output mem_pkg::addr_t         next_pc
);

    fetch_pkg::opcode_t opcode;
    mem_pkg::addr_t b_imm;
    mem_pkg::addr_t j_imm;
    mem_pkg::addr_t seq_pc;

    // opcode decode, unknown values fold into op_other
    always_comb begin
        case (instr[fetch_pkg::opcode_width-1:0])
            fetch_pkg::op_branch: opcode = fetch_pkg::op_branch;
            fetch_pkg::op_jal:    opcode = fetch_pkg::op_jal;
            fetch_pkg::op_jalr:   opcode = fetch_pkg::op_jalr;
            default:              opcode = fetch_pkg::op_other;
        endcase
    end

    // b-type immediate, sign extended
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // j-type immediate, sign extended
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign seq_pc = pc + mem_pkg::addr_t'(fetch_pkg::instr_bytes);

    assign is_cond_br = opcode == fetch_pkg::op_branch;

    // backward taken, forward not taken
    assign br_dir_pred = is_cond_br && b_imm[mem_pkg::addr_width-1];

    always_comb begin
        case (opcode)
            fetch_pkg::op_jal: begin
                // always taken
                next_pc = pc + j_imm;
            end
            fetch_pkg::op_branch: begin
                if (br_dir_pred) begin
                    next_pc = pc + b_imm;
                end else begin
                    next_pc = seq_pc;
                end
            end
            // jalr lands here too since its target lives in a register
            default: next_pc = seq_pc;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`default_nettype none

module icache (
    input  wire                  clk,
    input  wire                  rst,
    // lookup side
    input  wire mem_pkg::addr_t  pc,
    input  wire                  flush,
    output logic                 hit,
    output mem_pkg::block_data_t block,
    // block request to the memory controller
    output logic                 req_valid,
    output mem_pkg::block_addr_t req_block_addr,
    input  wire                  req_ready,
    // refill data, always accepted
    input  wire                  resp_valid,
    input  wire mem_pkg::block_data_t resp_block_data
);

    // fields of the current pc
    mem_pkg::icache_index_t index;
    mem_pkg::icache_tag_t   tag;

    // arrays, one entry per set
    mem_pkg::icache_tag_t   tag_arr [mem_pkg::icache_num_sets];
    mem_pkg::block_data_t   data_arr [mem_pkg::icache_num_sets];
    logic [mem_pkg::icache_num_sets-1:0] valid_arr;

    // refill control
    mem_pkg::refill_state_t state;
    mem_pkg::block_addr_t   miss_block_addr;
    mem_pkg::icache_index_t refill_index;
    mem_pkg::icache_tag_t   refill_tag;

    logic tag_match;
    logic start_refill;
    logic refill_done;

    // split pc into index and tag
    assign index = pc[mem_pkg::block_offset_bits +: mem_pkg::icache_index_bits];
    assign tag = pc[mem_pkg::addr_width-1 -: mem_pkg::icache_tag_bits];

    assign tag_match = tag_arr[index] == tag;

    // lookup only counts while no refill is running
    assign hit = (state == mem_pkg::idle) && valid_arr[index] && tag_match;
    assign block = data_arr[index];

    // a redirect this cycle replaces pc, so skip the stale miss
    assign start_refill = (state == mem_pkg::idle) && !hit && !flush;
    assign refill_done = (state == mem_pkg::wait_resp) && resp_valid;

    // set and tag of the block being filled
    assign refill_index = miss_block_addr[mem_pkg::icache_index_bits-1:0];
    assign refill_tag =
        miss_block_addr[mem_pkg::addr_width-mem_pkg::block_offset_bits-1 -:
                        mem_pkg::icache_tag_bits];

    // held from the request cycle until req_ready
    assign req_valid = state == mem_pkg::request;
    assign req_block_addr = miss_block_addr;

    // refill fsm and valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_pkg::idle;
            // reset invalidates every set
            valid_arr <= '0;
        end else begin
            case (state)
                mem_pkg::idle: begin
                    if (start_refill) begin
                        state <= mem_pkg::request;
                    end
                end
                mem_pkg::request: begin
                    // address accepted by memory
                    if (req_ready) begin
                        state <= mem_pkg::wait_resp;
                    end
                end
                mem_pkg::wait_resp: begin
                    // flush is ignored here, the block still lands
                    if (resp_valid) begin
                        state <= mem_pkg::idle;
                        valid_arr[refill_index] <= 1'b1;
                    end
                end
                default: begin
                    state <= mem_pkg::idle;
                end
            endcase
        end
    end

    // miss address latch
    always_ff @(posedge clk) begin
        if (start_refill) begin
            miss_block_addr <= pc[mem_pkg::addr_width-1:mem_pkg::block_offset_bits];
        end
    end

    // tag and data write on refill
    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_arr[refill_index] <= refill_tag;
            data_arr[refill_index] <= resp_block_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // fixed length encoding, no compressed forms
    localparam int instr_width = 32;
    localparam int instr_bytes = instr_width / 8;
    localparam int opcode_width = 7;

    typedef logic [instr_width-1:0] instr_t;

    // only the control flow opcodes matter to the predictor
    typedef enum logic [opcode_width-1:0] {
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        // anything else, falls through to pc + 4
        op_other  = 7'b0000000
    } opcode_t;

    // one queued fetch, about 98 bits
    typedef struct packed {
        instr_t         instr;
        mem_pkg::addr_t pc;
        logic           is_cond_br;
        logic           br_dir_pred;
        // predicted next pc, for every entry
        mem_pkg::addr_t br_target_pred;
    } ifetch_entry_t;

    // instruction queue sizing
    localparam int ififo_depth = 8;
    localparam int ififo_ptr_bits = $clog2(ififo_depth);
    // count needs one more bit to tell full from empty
    localparam int ififo_count_bits = $clog2(ififo_depth + 1);

    typedef logic [ififo_ptr_bits-1:0] ififo_ptr_t;
    typedef logic [ififo_count_bits-1:0] ififo_count_t;

    // first fetch address out of reset
    localparam mem_pkg::addr_t reset_vector = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // byte addressed, 32-bit space
    localparam int addr_width = 32;

    // one block holds two 32-bit instructions
    localparam int block_width = 64;
    localparam int block_offset_bits = 3;

    // direct mapped, one way
    localparam int icache_num_sets = 16;
    localparam int icache_index_bits = $clog2(icache_num_sets);

    // tag is everything above the index
    localparam int icache_tag_bits = addr_width - icache_index_bits - block_offset_bits;

    typedef logic [addr_width-1:0] addr_t;

    // lower word sits at the even word address
    typedef logic [block_width-1:0] block_data_t;

    // block number as seen by the memory controller
    typedef logic [addr_width-block_offset_bits-1:0] block_addr_t;

    // index is address bits 6 to 3
    typedef logic [icache_index_bits-1:0] icache_index_t;
    typedef logic [icache_tag_bits-1:0] icache_tag_t;

    // miss handling
    // idle also means the lookup path is live
    typedef enum logic [1:0] {
        idle,
        request,
        wait_resp
    } refill_state_t;

endpackage

`default_nettype wire
